// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // Architectural widths, fixed by the instruction set
    localparam int DATA_WIDTH = 64;
    localparam int INSTR_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_COUNT = 32;

    typedef logic [DATA_WIDTH-1:0] data_word_t;
    typedef logic [INSTR_WIDTH-1:0] instr_word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [10:0] opcode_t;
    // fs[4:2] operation, fs[1] inverts B, fs[0] inverts A
    typedef logic [4:0] alu_fs_t;
    typedef logic [1:0] pc_fs_t;

    // Register 31 is the zero register
    localparam reg_addr_t REG_ZERO = 5'd31;

    // ALU operation codes for fs[4:2]
    localparam logic [2:0] ALU_AND = 3'b000;
    localparam logic [2:0] ALU_OR = 3'b001;
    localparam logic [2:0] ALU_ADD = 3'b010;
    localparam logic [2:0] ALU_XOR = 3'b011;
    localparam logic [2:0] ALU_LSL = 3'b100;
    localparam logic [2:0] ALU_LSR = 3'b101;

    // PC functions
    localparam pc_fs_t PC_HOLD = 2'b00;
    localparam pc_fs_t PC_ADD4 = 2'b01;
    localparam pc_fs_t PC_ADDK = 2'b10;
    localparam pc_fs_t PC_RSVD = 2'b11;

    // R and D format opcodes, instr[31:21]
    localparam opcode_t OP_AND = 11'h450;
    localparam opcode_t OP_ADD = 11'h458;
    localparam opcode_t OP_ORR = 11'h550;
    localparam opcode_t OP_ADDS = 11'h558;
    localparam opcode_t OP_EOR = 11'h650;
    localparam opcode_t OP_SUB = 11'h658;
    localparam opcode_t OP_ANDS = 11'h750;
    localparam opcode_t OP_SUBS = 11'h758;
    localparam opcode_t OP_LSR = 11'h69A;
    localparam opcode_t OP_LSL = 11'h69B;
    localparam opcode_t OP_LDUR = 11'h7C2;
    localparam opcode_t OP_STUR = 11'h7C0;

    // Shorter opcodes of the I, B and CB formats
    localparam logic [9:0] OP_ADDI = 10'h244;
    localparam logic [9:0] OP_SUBI = 10'h344;
    localparam logic [5:0] OP_B = 6'b000101;
    localparam logic [7:0] OP_CBZ = 8'hB4;
    localparam logic [7:0] OP_BCOND = 8'h54;

    // B.cond condition codes in instr[4:0]
    localparam logic [4:0] COND_EQ = 5'h00;
    localparam logic [4:0] COND_NE = 5'h01;
    localparam logic [4:0] COND_GE = 5'h0A;
    localparam logic [4:0] COND_LT = 5'h0B;

    typedef struct packed {
        logic v;
        logic c;
        logic n;
        logic z;
    } status_flags_t;

    typedef enum logic [1:0] {
        ST_FETCH = 2'b00,
        ST_EXECUTE = 2'b01,
        ST_MEMORY = 2'b10,
        ST_WAIT_RELEASE = 2'b11
    } cpu_state_t;

    // 33-bit control word
    typedef struct packed {
        logic alu_en;
        logic alu_bs;
        alu_fs_t alu_fs;
        logic rf_b_en;
        reg_addr_t rf_sa;
        reg_addr_t rf_sb;
        reg_addr_t rf_da;
        logic rf_w;
        logic ram_en;
        logic ram_w;
        logic pc_en;
        pc_fs_t pc_fs;
        logic pc_is;
        logic status_ld;
        cpu_state_t next_state;
    } control_word_t;

endpackage

// ==== src/r_decoder.sv ====
`timescale 1ns/1ps

module r_decoder
    import cpu_pkg::*;
(
    input  instr_word_t   instr,
    output control_word_t control
);

    opcode_t opcode;

    assign opcode = instr[31:21];

    always_comb begin
        // Register to register form, Rd gets the ALU result
        control = '0;
        control.alu_en = 1'b1;
        control.alu_bs = 1'b0;
        control.alu_fs = {ALU_AND, 2'b00};
        control.rf_sa = instr[9:5];
        control.rf_sb = instr[20:16];
        control.rf_da = instr[4:0];
        control.rf_w = 1'b1;
        control.pc_en = 1'b1;
        control.pc_fs = PC_ADD4;
        control.next_state = ST_FETCH;

        case (opcode)
            OP_AND, OP_ANDS: control.alu_fs = {ALU_AND, 2'b00};
            OP_ORR: control.alu_fs = {ALU_OR, 2'b00};
            OP_ADD, OP_ADDS: control.alu_fs = {ALU_ADD, 2'b00};
            // Subtract as A plus inverted B
            OP_SUB, OP_SUBS: control.alu_fs = {ALU_ADD, 2'b10};
            OP_EOR: control.alu_fs = {ALU_XOR, 2'b00};
            // Shift amount comes in through K
            OP_LSL: begin
                control.alu_fs = {ALU_LSL, 2'b00};
                control.alu_bs = 1'b1;
            end
            OP_LSR: begin
                control.alu_fs = {ALU_LSR, 2'b00};
                control.alu_bs = 1'b1;
            end
            // Unknown opcode only advances the PC
            default: control.rf_w = 1'b0;
        endcase

        // S variants load the flags
        control.status_ld = (opcode == OP_ADDS) || (opcode == OP_SUBS) || (opcode == OP_ANDS);
    end

endmodule

// ==== src/imm_decoder.sv ====
`timescale 1ns/1ps

module imm_decoder
    import cpu_pkg::*;
(
    input  instr_word_t   instr,
    input  status_flags_t flags,
    output control_word_t control,
    output data_word_t    k
);

    // B.cond evaluation against the stored flags
    function automatic logic cond_true(input logic [4:0] cond, input status_flags_t f);
        case (cond)
            COND_EQ: cond_true = f.z;
            COND_NE: cond_true = !f.z;
            COND_GE: cond_true = (f.n == f.v);
            COND_LT: cond_true = (f.n != f.v);
            default: cond_true = 1'b0;
        endcase
    endfunction

    always_comb begin
        control = '0;
        control.alu_en = 1'b1;
        control.alu_fs = {ALU_ADD, 2'b00};
        control.rf_sa = instr[9:5];
        control.rf_sb = REG_ZERO;
        control.rf_da = instr[4:0];
        control.pc_en = 1'b1;
        control.pc_fs = PC_ADD4;
        control.next_state = ST_FETCH;
        // Shamt, so that R-format shifts find their amount in K
        k = {58'b0, instr[15:10]};

        casez (instr[31:21])
            {OP_ADDI, 1'b?}, {OP_SUBI, 1'b?}: begin
                // imm12 is zero extended
                k = {52'b0, instr[21:10]};
                control.alu_bs = 1'b1;
                control.alu_fs = {ALU_ADD, instr[30], 1'b0};
                control.rf_w = 1'b1;
            end
            OP_LDUR, OP_STUR: begin
                // Rn plus signed 9-bit address
                k = {{55{instr[20]}}, instr[20:12]};
                control.alu_bs = 1'b1;
                control.rf_sb = instr[4:0];
                control.rf_b_en = !instr[22];
                control.rf_w = instr[22];
                control.ram_en = 1'b1;
                control.ram_w = !instr[22];
                control.next_state = ST_MEMORY;
            end
            {OP_B, 5'b?????}: begin
                k = {{38{instr[25]}}, instr[25:0]};
                control.pc_fs = PC_ADDK;
            end
            {OP_CBZ, 3'b???}: begin
                // Rt OR zero, taken only if the result is zero
                k = {{45{instr[23]}}, instr[23:5]};
                control.rf_sa = instr[4:0];
                control.alu_fs = {ALU_OR, 2'b00};
                control.pc_fs = PC_ADDK;
                control.pc_is = 1'b1;
            end
            {OP_BCOND, 3'b???}: begin
                k = {{45{instr[23]}}, instr[23:5]};
                control.pc_fs = cond_true(instr[4:0], flags) ? PC_ADDK : PC_ADD4;
            end
            default: control.rf_w = 1'b0;
        endcase
    end

endmodule

// ==== src/control_sequencer.sv ====
`timescale 1ns/1ps

module control_sequencer
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
) (
    input  logic          clock,
    input  logic          reset,
    output logic          instr_req,
    input  instr_word_t   instr_data,
    input  logic          instr_ack,
    output logic          mem_req,
    input  logic          mem_ack,
    input  control_word_t r_control,
    input  control_word_t i_control,
    output instr_word_t   instr,
    input  logic          alu_zero,
    output control_word_t control,
    output logic          pc_load,
    output logic          rf_write,
    output logic          status_load
);

    cpu_state_t state;
    cpu_state_t state_next;
    // Where to go once the pending ack has dropped
    cpu_state_t release_target;
    control_word_t selected;
    logic act;

    // Byte addressing needs room for the two low zero bits
    if (ADDR_WIDTH < 3 || ADDR_WIDTH > DATA_WIDTH) begin : g_width_check
        $error("ADDR_WIDTH out of range");
    end

    // R-format data processing has 101 or 001 in bits 27 to 25
    assign selected = (instr[27:25] == 3'b101 || instr[27:25] == 3'b001) ? r_control : i_control;

    // Execute for register ops, memory ack for loads and stores
    assign act = (state == ST_EXECUTE && selected.next_state != ST_MEMORY)
                 || (state == ST_MEMORY && mem_ack);
    assign rf_write = act & selected.rf_w;
    assign status_load = act & selected.status_ld;
    assign pc_load = act & selected.pc_en;

    always_comb begin
        control = selected;
        // CBZ falls through when Rt is not zero
        if (selected.pc_is && !alu_zero) begin
            control.pc_fs = PC_ADD4;
        end
        control.rf_w = rf_write;
        control.status_ld = status_load;
        control.pc_en = pc_load;
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: if (instr_ack) state_next = ST_WAIT_RELEASE;
            ST_WAIT_RELEASE: begin
                if (release_target == ST_EXECUTE) begin
                    if (!instr_ack) state_next = ST_EXECUTE;
                end else if (!mem_ack) begin
                    state_next = ST_FETCH;
                end
            end
            ST_EXECUTE: state_next = (selected.next_state == ST_MEMORY) ? ST_MEMORY : ST_FETCH;
            ST_MEMORY: if (mem_ack) state_next = ST_WAIT_RELEASE;
            default: state_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_FETCH;
            release_target <= ST_FETCH;
            instr_req <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            state <= state_next;
            // Requests follow the state, one flop each
            instr_req <= (state_next == ST_FETCH);
            mem_req <= (state_next == ST_MEMORY);
            if (state == ST_FETCH) begin
                release_target <= ST_EXECUTE;
            end else if (state == ST_MEMORY) begin
                release_target <= ST_FETCH;
            end
        end
    end

    // Instruction register, loads on the fetch ack edge
    always_ff @(posedge clock) begin
        if (state == ST_FETCH && instr_ack) begin
            instr <= instr_data;
        end
    end

endmodule

// ==== src/program_counter.sv ====
`timescale 1ns/1ps

module program_counter
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load,
    input  pc_fs_t                pc_fs,
    input  data_word_t            offset,
    output logic [ADDR_WIDTH-1:0] pc
);

    // Word offset scaled to bytes
    logic [ADDR_WIDTH-1:0] byte_offset;

    assign byte_offset = {offset[ADDR_WIDTH-3:0], 2'b00};

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (load) begin
            case (pc_fs)
                PC_ADD4: pc <= pc + ADDR_WIDTH'(4);
                PC_ADDK: pc <= pc + byte_offset;
                PC_HOLD, PC_RSVD: pc <= pc;
            endcase
        end
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  reg_addr_t  sa,
    input  reg_addr_t  sb,
    input  reg_addr_t  da,
    input  logic       write,
    input  data_word_t wdata,
    output data_word_t a,
    output data_word_t b
);

    data_word_t regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && da != REG_ZERO) begin
            regs[da] <= wdata;
        end
    end

    // Combinational reads, XZR reads zero
    assign a = (sa == REG_ZERO) ? '0 : regs[sa];
    assign b = (sb == REG_ZERO) ? '0 : regs[sb];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  data_word_t    a,
    input  data_word_t    b,
    input  alu_fs_t       fs,
    input  logic          status_ld,
    output data_word_t    result,
    output logic          zero,
    output status_flags_t flags
);

    data_word_t a_in;
    data_word_t b_in;
    data_word_t sum;
    logic carry;
    logic is_add;
    status_flags_t next_flags;

    assign a_in = fs[0] ? ~a : a;
    assign b_in = fs[1] ? ~b : b;
    // Carry in of one turns the inverted operand into its negative
    assign {carry, sum} = {1'b0, a_in} + {1'b0, b_in} + {64'b0, fs[1] ^ fs[0]};

    always_comb begin
        case (fs[4:2])
            ALU_AND: result = a_in & b_in;
            ALU_OR: result = a_in | b_in;
            ALU_ADD: result = sum;
            ALU_XOR: result = a_in ^ b_in;
            // Shift amount from the low 6 bits of B
            ALU_LSL: result = a_in << b[5:0];
            ALU_LSR: result = a_in >> b[5:0];
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

    // C and V only mean something for the adder
    assign is_add = (fs[4:2] == ALU_ADD);
    assign next_flags.v = is_add & (a_in[DATA_WIDTH-1] == b_in[DATA_WIDTH-1])
                          & (sum[DATA_WIDTH-1] != a_in[DATA_WIDTH-1]);
    assign next_flags.c = is_add & carry;
    assign next_flags.n = result[DATA_WIDTH-1];
    assign next_flags.z = zero;

    always_ff @(posedge clock) begin
        if (reset) begin
            flags <= '0;
        end else if (status_ld) begin
            flags <= next_flags;
        end
    end

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  instr_req,
    output logic [ADDR_WIDTH-1:0] instr_addr,
    input  instr_word_t           instr_data,
    input  logic                  instr_ack,
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output data_word_t            mem_wdata,
    input  data_word_t            mem_rdata,
    input  logic                  mem_ack
);

    instr_word_t instr;
    control_word_t r_control;
    control_word_t i_control;
    control_word_t control;
    data_word_t k;
    data_word_t rf_a;
    data_word_t rf_b;
    data_word_t alu_b;
    data_word_t alu_result;
    data_word_t rf_wdata;
    status_flags_t flags;
    logic alu_zero;
    logic pc_load;
    logic rf_write;
    logic status_load;

    r_decoder u_r_decoder (
        .instr   (instr),
        .control (r_control)
    );

    imm_decoder u_imm_decoder (
        .instr   (instr),
        .flags   (flags),
        .control (i_control),
        .k       (k)
    );

    control_sequencer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_control_sequencer (
        .clock       (clock),
        .reset       (reset),
        .instr_req   (instr_req),
        .instr_data  (instr_data),
        .instr_ack   (instr_ack),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .r_control   (r_control),
        .i_control   (i_control),
        .instr       (instr),
        .alu_zero    (alu_zero),
        .control     (control),
        .pc_load     (pc_load),
        .rf_write    (rf_write),
        .status_load (status_load)
    );

    program_counter #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_program_counter (
        .clock  (clock),
        .reset  (reset),
        .load   (pc_load),
        .pc_fs  (control.pc_fs),
        .offset (k),
        .pc     (instr_addr)
    );

    register_file u_register_file (
        .clock (clock),
        .reset (reset),
        .sa    (control.rf_sa),
        .sb    (control.rf_sb),
        .da    (control.rf_da),
        .write (rf_write),
        .wdata (rf_wdata),
        .a     (rf_a),
        .b     (rf_b)
    );

    // B operand from the register file or from K
    assign alu_b = control.alu_bs ? k : rf_b;

    alu u_alu (
        .clock     (clock),
        .reset     (reset),
        .a         (rf_a),
        .b         (alu_b),
        .fs        (control.alu_fs),
        .status_ld (status_load),
        .result    (alu_result),
        .zero      (alu_zero),
        .flags     (flags)
    );

    // Write-back from memory for loads, else the ALU
    assign rf_wdata = (control.ram_en && !control.ram_w) ? mem_rdata : alu_result;

    // Data port, address is Rn plus offset
    assign mem_addr = alu_result[ADDR_WIDTH-1:0];
    assign mem_write = control.ram_en & control.ram_w;
    assign mem_wdata = control.rf_b_en ? rf_b : '0;

endmodule

// ==== bench/cpu_core_assertions.sv ====
`timescale 1ns/1ps

module cpu_core_assertions #(
    parameter int ADDR_WIDTH = 16
) (
    input logic                  clock,
    input logic                  reset,
    input logic                  instr_req,
    input logic                  instr_ack,
    input logic [ADDR_WIDTH-1:0] instr_addr,
    input logic                  mem_req,
    input logic                  mem_ack,
    input logic                  mem_write,
    input logic [ADDR_WIDTH-1:0] mem_addr
);

    // Failed assertions so far
    int failures = 0;

    // Req held until ack
    instr_req_held: assert property (@(posedge clock) disable iff (reset)
        instr_req && !instr_ack |=> instr_req)
        else begin
            $error("instr_req dropped before instr_ack");
            failures = failures + 1;
        end
    mem_req_held: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req)
        else begin
            $error("mem_req dropped before mem_ack");
            failures = failures + 1;
        end

    // Address steady for the whole request
    instr_addr_stable: assert property (@(posedge clock) disable iff (reset)
        instr_req |=> !instr_req || $stable(instr_addr))
        else begin
            $error("instr_addr changed while instr_req was high");
            failures = failures + 1;
        end
    mem_addr_stable: assert property (@(posedge clock) disable iff (reset)
        mem_req |=> !mem_req || $stable({mem_write, mem_addr}))
        else begin
            $error("mem_addr or mem_write changed while mem_req was high");
            failures = failures + 1;
        end

    // New request only once the last ack is gone
    // Ack is looked at on the edge that raised req
    instr_req_order: assert property (@(posedge clock) disable iff (reset)
        $rose(instr_req) |-> !$past(instr_ack))
        else begin
            $error("instr_req rose while instr_ack was still high");
            failures = failures + 1;
        end
    mem_req_order: assert property (@(posedge clock) disable iff (reset)
        $rose(mem_req) |-> !$past(mem_ack))
        else begin
            $error("mem_req rose while mem_ack was still high");
            failures = failures + 1;
        end

    // Both ports idle out of reset
    req_low_after_reset: assert property (@(posedge clock)
        reset |=> !instr_req && !mem_req)
        else begin
            $error("a req output was high after reset");
            failures = failures + 1;
        end

endmodule

bind cpu_core cpu_core_assertions #(
    .ADDR_WIDTH (ADDR_WIDTH)
) u_cpu_core_assertions (
    .clock      (clock),
    .reset      (reset),
    .instr_req  (instr_req),
    .instr_ack  (instr_ack),
    .instr_addr (instr_addr),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr)
);

// ==== bench/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int ADDR_WIDTH = 16;
    localparam int TIMEOUT_CYCLES = 50;

    // One fetch of the program, in execution order
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        instr_word_t instr;
        logic store;
        logic [ADDR_WIDTH-1:0] addr;
        data_word_t value;
    } step_t;

    // Store seen on the data port
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        data_word_t data;
    } store_rec_t;

    logic clock;
    logic reset;
    logic instr_req;
    logic [ADDR_WIDTH-1:0] instr_addr;
    instr_word_t instr_data;
    logic instr_ack;
    logic mem_req;
    logic mem_write;
    logic [ADDR_WIDTH-1:0] mem_addr;
    data_word_t mem_wdata;
    data_word_t mem_rdata = '0;
    logic mem_ack = 1'b0;

    step_t prog[$];
    store_rec_t stores[$];
    logic [ADDR_WIDTH-1:0] pc_model = '0;
    int delay_left = 0;

    cpu_core #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_cpu_core (
        .clock      (clock),
        .reset      (reset),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .instr_ack  (instr_ack),
        .mem_req    (mem_req),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Instruction encoders for each format
    function automatic instr_word_t r_format(opcode_t op, reg_addr_t rm, logic [5:0] shamt,
                                             reg_addr_t rn, reg_addr_t rd);
        return {op, rm, shamt, rn, rd};
    endfunction

    function automatic instr_word_t i_format(logic [9:0] op, logic [11:0] imm,
                                             reg_addr_t rn, reg_addr_t rd);
        return {op, imm, rn, rd};
    endfunction

    function automatic instr_word_t d_format(opcode_t op, logic [8:0] offset,
                                             reg_addr_t rn, reg_addr_t rt);
        return {op, offset, 2'b00, rn, rt};
    endfunction

    function automatic instr_word_t cb_format(logic [7:0] op, logic [18:0] offset,
                                              logic [4:0] rt);
        return {op, offset, rt};
    endfunction

    // Data memory contents, every address bit matters
    function automatic data_word_t fill(logic [ADDR_WIDTH-1:0] addr);
        return {4{addr}} ^ 64'hF0E1_D2C3_B4A5_9687;
    endfunction

    // Architectural result of the R-format operations
    function automatic data_word_t r_result(opcode_t op, data_word_t a, data_word_t b);
        case (op)
            OP_AND, OP_ANDS: return a & b;
            OP_ORR: return a | b;
            OP_ADD, OP_ADDS: return a + b;
            OP_SUB, OP_SUBS: return a - b;
            OP_EOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    // Condition outcome after SUBS a, b as a signed compare
    function automatic logic cond_after_subs(logic [4:0] cond, data_word_t a, data_word_t b);
        case (cond)
            COND_EQ: return a == b;
            COND_NE: return a != b;
            COND_LT: return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch(input string name, input data_word_t expected,
                            input data_word_t actual);
        fail_with($sformatf("FAIL at %0d ns: %s expected %h got %h",
                            $time, name, expected, actual));
    endtask

    task automatic await_instr_req(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_with($sformatf("Timeout, instr_req never went to %0b", level));
            end
        end while (instr_req !== level);
    endtask

    task automatic await_store();
        int cycles;
        cycles = 0;
        while (stores.size() == 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_with("Timeout, the expected store never reached the data port");
            end
        end
    endtask

    task automatic append(input instr_word_t instr);
        prog.push_back(step_t'{pc: pc_model, instr: instr, store: 1'b0, addr: '0, value: '0});
        pc_model = pc_model + 16'd4;
    endtask

    task automatic expect_store(input instr_word_t instr, input logic [ADDR_WIDTH-1:0] addr,
                                input data_word_t value);
        prog.push_back(step_t'{pc: pc_model, instr: instr, store: 1'b1, addr: addr,
                               value: value});
        pc_model = pc_model + 16'd4;
    endtask

    // Taken branches move by words times 4
    task automatic branch(input instr_word_t instr, input logic taken, input int words);
        prog.push_back(step_t'{pc: pc_model, instr: instr, store: 1'b0, addr: '0, value: '0});
        pc_model = taken ? pc_model + 16'(words * 4) : pc_model + 16'd4;
    endtask

    task automatic build_program();
        opcode_t ops[8];
        data_word_t x1;
        data_word_t x2;
        data_word_t x3;
        ops = '{OP_AND, OP_ORR, OP_ADD, OP_SUB, OP_EOR, OP_ADDS, OP_SUBS, OP_ANDS};
        x1 = 64'd1234;
        x2 = 64'hABC;
        x3 = x1 - 64'd2000;
        // Operands, imm12 is unsigned so X3 goes negative
        append(i_format(OP_ADDI, 12'd1234, REG_ZERO, 5'd1));
        append(i_format(OP_ADDI, 12'hABC, REG_ZERO, 5'd2));
        append(i_format(OP_SUBI, 12'd2000, 5'd1, 5'd3));
        expect_store(d_format(OP_STUR, 9'd8, REG_ZERO, 5'd3), 16'd8, x3);
        foreach (ops[i]) begin
            append(r_format(ops[i], 5'd2, 6'd0, 5'd1, 5'd4));
            expect_store(d_format(OP_STUR, 9'(16 + 8 * i), REG_ZERO, 5'd4), 16'(16 + 8 * i),
                         r_result(ops[i], x1, x2));
        end
        append(r_format(OP_LSL, 5'd0, 6'd7, 5'd1, 5'd5));
        expect_store(d_format(OP_STUR, 9'd96, REG_ZERO, 5'd5), 16'd96, x1 << 7);
        append(r_format(OP_LSR, 5'd0, 6'd3, 5'd3, 5'd5));
        expect_store(d_format(OP_STUR, 9'd104, REG_ZERO, 5'd5), 16'd104, x3 >> 3);
        // Load at X1 minus 4, then use it
        append(d_format(OP_LDUR, 9'h1FC, 5'd1, 5'd6));
        append(r_format(OP_ADD, 5'd2, 6'd0, 5'd6, 5'd7));
        expect_store(d_format(OP_STUR, 9'd112, REG_ZERO, 5'd7), 16'd112,
                     fill(16'(x1 - 64'd4)) + x2);
        append(d_format(OP_LDUR, 9'd16, 5'd2, 5'd8));
        expect_store(d_format(OP_STUR, 9'd0, 5'd1, 5'd8), 16'(x1), fill(16'(x2 + 64'd16)));
        // Flags from SUBS, then B.cond
        append(r_format(OP_SUBS, 5'd1, 6'd0, 5'd1, 5'd9));
        branch(cb_format(OP_BCOND, 19'd3, COND_EQ), cond_after_subs(COND_EQ, x1, x1), 3);
        append(r_format(OP_SUBS, 5'd1, 6'd0, 5'd3, 5'd9));
        branch(cb_format(OP_BCOND, 19'd5, COND_GE), cond_after_subs(COND_GE, x3, x1), 5);
        branch(cb_format(OP_BCOND, 19'd2, COND_LT), cond_after_subs(COND_LT, x3, x1), 2);
        append(r_format(OP_SUBS, 5'd3, 6'd0, 5'd1, 5'd9));
        branch(cb_format(OP_BCOND, 19'd4, COND_EQ), cond_after_subs(COND_EQ, x1, x3), 4);
        branch(cb_format(OP_BCOND, 19'(-2), COND_NE), cond_after_subs(COND_NE, x1, x3), -2);
        // ANDS sets Z only from the result
        append(r_format(OP_ANDS, 5'd2, 6'd0, 5'd1, 5'd9));
        branch(cb_format(OP_BCOND, 19'd3, COND_EQ), (x1 & x2) == '0, 3);
        branch(cb_format(OP_BCOND, 19'd2, COND_NE), (x1 & x2) != '0, 2);
        // B, CBZ and the zero register
        branch({OP_B, 26'd4}, 1'b1, 4);
        branch(cb_format(OP_CBZ, 19'(-2), REG_ZERO), 1'b1, -2);
        branch(cb_format(OP_CBZ, 19'd6, 5'd1), x1 == '0, 6);
        append(i_format(OP_ADDI, 12'd77, 5'd1, REG_ZERO));
        expect_store(d_format(OP_STUR, 9'd120, REG_ZERO, REG_ZERO), 16'd120, '0);
        branch({OP_B, 26'(-3)}, 1'b1, -3);
    endtask

    // Data memory, ack after 1 to 4 falling edges
    always @(negedge clock) begin
        if (reset) begin
            mem_ack = 1'b0;
            delay_left = 0;
        end else if (mem_req && !mem_ack) begin
            if (delay_left == 0) begin
                delay_left = $urandom_range(4, 1);
            end
            delay_left = delay_left - 1;
            if (delay_left == 0) begin
                if (mem_write) begin
                    stores.push_back(store_rec_t'{addr: mem_addr, data: mem_wdata});
                end else begin
                    mem_rdata = fill(mem_addr);
                end
                mem_ack = 1'b1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack = 1'b0;
        end
    end

    // Instruction memory and checks, one table step per fetch
    initial begin : stimulus
        store_rec_t got;
        void'($urandom(26573));
        reset = 1'b1;
        instr_ack = 1'b0;
        instr_data = '0;
        build_program();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            await_instr_req(1'b1);
            assert (instr_addr == prog[i].pc)
                else mismatch("instr_addr", {48'b0, prog[i].pc}, {48'b0, instr_addr});
            instr_data = prog[i].instr;
            instr_ack = 1'b1;
            await_instr_req(1'b0);
            instr_ack = 1'b0;
            if (prog[i].store) begin
                await_store();
                got = stores.pop_front();
                assert (got.addr == prog[i].addr)
                    else mismatch("mem_addr", {48'b0, prog[i].addr}, {48'b0, got.addr});
                assert (got.data == prog[i].value)
                    else mismatch("mem_wdata", prog[i].value, got.data);
            end
        end
        // Last branch decides the next fetch
        await_instr_req(1'b1);
        assert (instr_addr == pc_model)
            else mismatch("instr_addr", {48'b0, pc_model}, {48'b0, instr_addr});
        assert (stores.size() == 0)
            else fail_with("A store reached the data port that the program does not contain");
        // Handshake order and stability come from the bound checker
        if (u_cpu_core.u_cpu_core_assertions.failures != 0) begin
            fail_with("A handshake assertion on the instruction or data port failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== cpu_core.f ====
src/cpu_pkg.sv
src/r_decoder.sv
src/imm_decoder.sv
src/control_sequencer.sv
src/program_counter.sv
src/register_file.sv
src/alu.sv
src/cpu_core.sv
bench/cpu_core_assertions.sv
bench/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert
TOP        := cpu_core_tb
FILELIST   := cpu_core.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
